// ==== hdl/alu_pkg.sv ====
package alu_pkg;

  ////////////////////////////////////////////////////////////
  // data path widths
  ////////////////////////////////////////////////////////////

  // full word width and number of byte lanes in it
  localparam int WORD_W    = 32;
  localparam int LANES_MAX = 4;

  typedef logic [WORD_W-1:0]         word_t;
  // one flag per byte lane
  typedef logic [LANES_MAX-1:0]      lane_mask_t;
  // shift amount, bit index or divider step count
  typedef logic [$clog2(WORD_W)-1:0] shamt_t;

  ////////////////////////////////////////////////////////////
  // opcodes and lane modes
  ////////////////////////////////////////////////////////////

  // division codes sit at the top of the range
  // bit 0 selects signed, bit 1 selects the remainder
  typedef enum logic [4:0] {
    ALU_ADD  = 5'd0,  ALU_SUB  = 5'd1,
    ALU_AND  = 5'd2,  ALU_OR   = 5'd3,  ALU_XOR  = 5'd4,
    ALU_SLL  = 5'd5,  ALU_SRL  = 5'd6,  ALU_SRA  = 5'd7,  ALU_ROR  = 5'd8,
    ALU_EQ   = 5'd9,  ALU_NE   = 5'd10,
    ALU_GTS  = 5'd11, ALU_GES  = 5'd12, ALU_LTS  = 5'd13, ALU_LES  = 5'd14,
    ALU_GTU  = 5'd15, ALU_GEU  = 5'd16, ALU_LTU  = 5'd17, ALU_LEU  = 5'd18,
    ALU_SLTS = 5'd19, ALU_SLTU = 5'd20,
    ALU_MIN  = 5'd21, ALU_MINU = 5'd22, ALU_MAX  = 5'd23, ALU_MAXU = 5'd24,
    ALU_DIVU = 5'd28, ALU_DIV  = 5'd29, ALU_REMU = 5'd30, ALU_REM  = 5'd31
  } alu_op_e;

  // 2'b01 is left unused
  typedef enum logic [1:0] {
    VEC_MODE32 = 2'b00,
    VEC_MODE16 = 2'b10,
    VEC_MODE8  = 2'b11
  } vec_mode_e;

endpackage

// ==== hdl/vec_adder.sv ====
`timescale 1ns/1ps

module vec_adder (
  input  alu_pkg::alu_op_e    operator_i,
  input  alu_pkg::vec_mode_e  vector_mode_i,
  input  alu_pkg::word_t      operand_a_i,
  input  alu_pkg::word_t      operand_b_i,
  output alu_pkg::word_t      sum_o
);

  // 4 bytes plus one guard bit below each byte
  localparam int EXT_W = alu_pkg::WORD_W + alu_pkg::LANES_MAX;

  logic                do_sub;
  alu_pkg::word_t      op_b;
  alu_pkg::lane_mask_t lane_start;
  logic [EXT_W-1:0]    in_a;
  logic [EXT_W-1:0]    in_b;
  logic [EXT_W-1:0]    sum_ext;

  assign do_sub = (operator_i == alu_pkg::ALU_SUB);
  // subtract as a + ~b + 1, the +1 comes from the guard bits
  assign op_b   = do_sub ? ~operand_b_i : operand_b_i;

  // byte i opens a new lane in this mode
  assign lane_start[0] = 1'b1;
  assign lane_start[1] = (vector_mode_i == alu_pkg::VEC_MODE8);
  assign lane_start[2] = (vector_mode_i == alu_pkg::VEC_MODE8) ||
                         (vector_mode_i == alu_pkg::VEC_MODE16);
  assign lane_start[3] = (vector_mode_i == alu_pkg::VEC_MODE8);

  always_comb begin
    for (int i = 0; i < alu_pkg::LANES_MAX; i++) begin
      // default guard 1+0 passes the carry from the byte below
      in_a[9*i +: 9] = {operand_a_i[8*i +: 8], 1'b1};
      in_b[9*i +: 9] = {op_b[8*i +: 8], 1'b0};
      if (lane_start[i]) begin
        if (do_sub) begin
          // 1+1 always carries out, one carry-in per lane
          in_b[9*i] = 1'b1;
        end else begin
          // 0+0 swallows the carry of the lane below
          in_a[9*i] = 1'b0;
        end
      end
    end
  end

  assign sum_ext = in_a + in_b;

  // drop the guard positions
  always_comb begin
    for (int i = 0; i < alu_pkg::LANES_MAX; i++) begin
      sum_o[8*i +: 8] = sum_ext[9*i+1 +: 8];
    end
  end

endmodule

// ==== hdl/vec_shifter.sv ====
`timescale 1ns/1ps

module vec_shifter (
  input  alu_pkg::alu_op_e    operator_i,
  input  alu_pkg::vec_mode_e  vector_mode_i,
  input  alu_pkg::word_t      operand_a_i,
  input  alu_pkg::word_t      operand_b_i,
  output alu_pkg::word_t      shift_result_o
);

  logic                           shift_left;
  logic                           shift_arith;
  logic                           do_ror;
  alu_pkg::word_t                 shift_in;
  alu_pkg::word_t                 shift_amt;
  alu_pkg::word_t                 right_result;
  logic [2*alu_pkg::WORD_W-1:0]   wide_in;
  logic [2*alu_pkg::WORD_W-1:0]   wide_shifted;
  logic signed [16:0]             half_ext;
  logic signed [8:0]              byte_ext;

  // mirror a word end to end
  function automatic alu_pkg::word_t reverse_bits(input alu_pkg::word_t v);
    alu_pkg::word_t r;
    for (int k = 0; k < alu_pkg::WORD_W; k++) begin
      r[k] = v[alu_pkg::WORD_W-1-k];
    end
    return r;
  endfunction

  assign shift_left  = (operator_i == alu_pkg::ALU_SLL);
  assign shift_arith = (operator_i == alu_pkg::ALU_SRA);
  assign do_ror      = (operator_i == alu_pkg::ALU_ROR);

  // left shift is a right shift of the mirrored word
  assign shift_in = shift_left ? reverse_bits(operand_a_i) : operand_a_i;

  // mirroring also swaps the lanes, so the amounts follow them
  always_comb begin
    shift_amt = operand_b_i;
    if (shift_left) begin
      case (vector_mode_i)
        alu_pkg::VEC_MODE16: shift_amt = {operand_b_i[15:0], operand_b_i[31:16]};
        alu_pkg::VEC_MODE8:  shift_amt = {operand_b_i[7:0], operand_b_i[15:8],
                                          operand_b_i[23:16], operand_b_i[31:24]};
        default:             shift_amt = operand_b_i;
      endcase
    end
  end

  // 32-bit path, rotate reads the doubled word
  assign wide_in = do_ror ? {shift_in, shift_in} :
                   {{alu_pkg::WORD_W{shift_arith & shift_in[31]}}, shift_in};
  assign wide_shifted = wide_in >> shift_amt[4:0];

  always_comb begin
    half_ext     = '0;
    byte_ext     = '0;
    right_result = wide_shifted[alu_pkg::WORD_W-1:0];
    case (vector_mode_i)
      alu_pkg::VEC_MODE16: begin
        // 4 amount bits per halfword
        for (int h = 0; h < 2; h++) begin
          half_ext = {shift_arith & shift_in[16*h+15], shift_in[16*h +: 16]};
          half_ext = half_ext >>> shift_amt[16*h +: 4];
          right_result[16*h +: 16] = half_ext[15:0];
        end
      end
      alu_pkg::VEC_MODE8: begin
        // 3 amount bits per byte
        for (int b = 0; b < alu_pkg::LANES_MAX; b++) begin
          byte_ext = {shift_arith & shift_in[8*b+7], shift_in[8*b +: 8]};
          byte_ext = byte_ext >>> shift_amt[8*b +: 3];
          right_result[8*b +: 8] = byte_ext[7:0];
        end
      end
      default: ;
    endcase
  end

  // undo the mirror for left shifts
  assign shift_result_o = shift_left ? reverse_bits(right_result) : right_result;

  // decode upstream never hands over the spare mode code
  always_comb begin
    a_mode_legal: assert final ($isunknown(vector_mode_i) ||
      vector_mode_i inside {alu_pkg::VEC_MODE32, alu_pkg::VEC_MODE16, alu_pkg::VEC_MODE8});
  end

endmodule

// ==== hdl/vec_compare.sv ====
`timescale 1ns/1ps

module vec_compare (
  input  alu_pkg::alu_op_e     operator_i,
  input  alu_pkg::vec_mode_e   vector_mode_i,
  input  alu_pkg::word_t       operand_a_i,
  input  alu_pkg::word_t       operand_b_i,
  output alu_pkg::lane_mask_t  cmp_lanes_o,
  output alu_pkg::word_t       minmax_o
);

  logic                signed_op;
  logic                do_min;
  alu_pkg::lane_mask_t cmp_signed;
  alu_pkg::lane_mask_t eq_byte;
  alu_pkg::lane_mask_t gt_byte;
  alu_pkg::lane_mask_t is_equal;
  alu_pkg::lane_mask_t is_greater;
  alu_pkg::lane_mask_t sel_a;

  assign signed_op = operator_i inside {alu_pkg::ALU_GTS, alu_pkg::ALU_GES, alu_pkg::ALU_LTS,
                                        alu_pkg::ALU_LES, alu_pkg::ALU_SLTS,
                                        alu_pkg::ALU_MIN, alu_pkg::ALU_MAX};

  // only the top byte of each lane carries the sign
  always_comb begin
    cmp_signed = '0;
    if (signed_op) begin
      case (vector_mode_i)
        alu_pkg::VEC_MODE8:  cmp_signed = 4'b1111;
        alu_pkg::VEC_MODE16: cmp_signed = 4'b1010;
        default:             cmp_signed = 4'b1000;
      endcase
    end
  end

  // per byte flags, extra top bit makes the compare signed or not
  for (genvar i = 0; i < alu_pkg::LANES_MAX; i++) begin : g_byte
    assign eq_byte[i] = (operand_a_i[8*i +: 8] == operand_b_i[8*i +: 8]);
    assign gt_byte[i] =
      $signed({cmp_signed[i] & operand_a_i[8*i+7], operand_a_i[8*i +: 8]}) >
      $signed({cmp_signed[i] & operand_b_i[8*i+7], operand_b_i[8*i +: 8]});
  end

  // wider lanes, the upper byte wins unless it ties
  always_comb begin
    is_equal   = {4{&eq_byte}};
    is_greater = {4{gt_byte[3] | (eq_byte[3] & (gt_byte[2] |
                   (eq_byte[2] & (gt_byte[1] | (eq_byte[1] & gt_byte[0])))))}};
    case (vector_mode_i)
      alu_pkg::VEC_MODE16: begin
        is_equal   = {{2{eq_byte[3] & eq_byte[2]}}, {2{eq_byte[1] & eq_byte[0]}}};
        is_greater = {{2{gt_byte[3] | (eq_byte[3] & gt_byte[2])}},
                      {2{gt_byte[1] | (eq_byte[1] & gt_byte[0])}}};
      end
      alu_pkg::VEC_MODE8: begin
        is_equal   = eq_byte;
        is_greater = gt_byte;
      end
      default: ;
    endcase
  end

  // relation per opcode
  always_comb begin
    case (operator_i)
      alu_pkg::ALU_EQ:                   cmp_lanes_o = is_equal;
      alu_pkg::ALU_NE:                   cmp_lanes_o = ~is_equal;
      alu_pkg::ALU_GTS, alu_pkg::ALU_GTU: cmp_lanes_o = is_greater;
      alu_pkg::ALU_GES, alu_pkg::ALU_GEU: cmp_lanes_o = is_greater | is_equal;
      alu_pkg::ALU_LTS, alu_pkg::ALU_LTU,
      alu_pkg::ALU_SLTS, alu_pkg::ALU_SLTU: cmp_lanes_o = ~(is_greater | is_equal);
      alu_pkg::ALU_LES, alu_pkg::ALU_LEU: cmp_lanes_o = ~is_greater;
      default:                           cmp_lanes_o = '0;
    endcase
  end

  // keep a where it is greater for max, flip for min
  assign do_min = (operator_i == alu_pkg::ALU_MIN) || (operator_i == alu_pkg::ALU_MINU);
  assign sel_a  = is_greater ^ {alu_pkg::LANES_MAX{do_min}};

  for (genvar j = 0; j < alu_pkg::LANES_MAX; j++) begin : g_minmax
    assign minmax_o[8*j +: 8] = sel_a[j] ? operand_a_i[8*j +: 8] : operand_b_i[8*j +: 8];
  end

endmodule

// ==== hdl/serial_div.sv ====
`timescale 1ns/1ps

module serial_div (
  input  logic              clk,
  input  logic              reset_i,
  input  logic              enable_i,
  input  alu_pkg::alu_op_e  operator_i,
  input  alu_pkg::word_t    operand_a_i,
  input  alu_pkg::word_t    operand_b_i,
  input  logic              ex_ready_i,
  output alu_pkg::word_t    div_result_o,
  output logic              ready_o
);

  typedef enum logic [1:0] {
    IDLE,
    BUSY,
    DONE
  } div_state_e;

  div_state_e                     state_q, state_d;
  alu_pkg::shamt_t                count_q;
  logic                           is_div;
  logic                           op_signed;
  logic                           start;
  logic                           a_neg, b_neg;
  alu_pkg::word_t                 a_mag, b_mag;
  // quotient shifts in from the bottom while the dividend leaves at the top
  alu_pkg::word_t                 quot_q;
  alu_pkg::word_t                 rem_q;
  alu_pkg::word_t                 divisor_q;
  logic                           neg_quot_q, neg_rem_q, want_rem_q;
  logic [alu_pkg::WORD_W+1:0]     trial;

  ////////////////////////////////////////////////////////////
  // operand preparation
  ////////////////////////////////////////////////////////////

  assign is_div    = operator_i inside {alu_pkg::ALU_DIV, alu_pkg::ALU_DIVU,
                                        alu_pkg::ALU_REM, alu_pkg::ALU_REMU};
  assign op_signed = operator_i[0];
  assign start     = enable_i && is_div && (state_q == IDLE);

  // magnitudes, the most negative value maps onto itself as unsigned
  assign a_neg = op_signed & operand_a_i[alu_pkg::WORD_W-1];
  assign b_neg = op_signed & operand_b_i[alu_pkg::WORD_W-1];
  assign a_mag = a_neg ? -operand_a_i : operand_a_i;
  assign b_mag = b_neg ? -operand_b_i : operand_b_i;

  // one restoring step, top bit set means the divisor did not fit
  assign trial = {1'b0, rem_q, quot_q[alu_pkg::WORD_W-1]} - {2'b00, divisor_q};

  ////////////////////////////////////////////////////////////
  // state machine
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:    if (start) state_d = BUSY;
      BUSY:    if (count_q == '0) state_d = DONE;
      // hold the result until the consumer takes it
      DONE:    if (ex_ready_i) state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      state_q <= IDLE;
      count_q <= '0;
    end else begin
      state_q <= state_d;
      if (start) begin
        count_q <= '1;
      end else if (state_q == BUSY) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // datapath
  always_ff @(posedge clk) begin
    if (start) begin
      quot_q     <= a_mag;
      rem_q      <= '0;
      divisor_q  <= b_mag;
      want_rem_q <= operator_i[1];
      neg_rem_q  <= a_neg;
      // divide by zero keeps the all ones quotient unsigned
      neg_quot_q <= (a_neg ^ b_neg) && (operand_b_i != '0);
    end else if (state_q == BUSY) begin
      if (trial[alu_pkg::WORD_W+1]) begin
        rem_q <= {rem_q[alu_pkg::WORD_W-2:0], quot_q[alu_pkg::WORD_W-1]};
      end else begin
        rem_q <= trial[alu_pkg::WORD_W-1:0];
      end
      quot_q <= {quot_q[alu_pkg::WORD_W-2:0], ~trial[alu_pkg::WORD_W+1]};
    end
  end

  // sign fix on the way out, remainder takes the dividend sign
  assign div_result_o = want_rem_q ? (neg_rem_q ? -rem_q : rem_q) :
                                     (neg_quot_q ? -quot_q : quot_q);
  assign ready_o      = (state_q != BUSY);

  // ready drops for the whole 32 step run and comes back after it
  a_busy_not_ready: assert property (@(posedge clk) disable iff (reset_i)
    start |=> (!ready_o) [*32] ##1 ready_o);

  // back-pressure freezes the result
  a_done_stable: assert property (@(posedge clk) disable iff (reset_i)
    (state_q == DONE) && !ex_ready_i |=> (state_q == DONE) && $stable(div_result_o));

endmodule

// ==== hdl/alu_top.sv ====
`timescale 1ns/1ps

module alu_top (
  input  logic                clk,
  input  logic                reset_i,
  input  logic                enable_i,
  input  alu_pkg::alu_op_e    operator_i,
  input  alu_pkg::vec_mode_e  vector_mode_i,
  input  alu_pkg::word_t      operand_a_i,
  input  alu_pkg::word_t      operand_b_i,
  input  logic                ex_ready_i,
  output alu_pkg::word_t      result_o,
  output logic                comparison_result_o,
  output logic                ready_o
);

  // unit outputs
  alu_pkg::word_t     adder_sum;
  alu_pkg::word_t     shift_res;
  alu_pkg::word_t     minmax_res;
  alu_pkg::word_t     div_res;
  alu_pkg::lane_mask_t cmp_lanes;

  ////////////////////////////////////////////////////////////
  // execution units
  ////////////////////////////////////////////////////////////

  // every unit sees the raw opcode and decodes it itself
  vec_adder u_adder (
    .operator_i    (operator_i),
    .vector_mode_i (vector_mode_i),
    .operand_a_i   (operand_a_i),
    .operand_b_i   (operand_b_i),
    .sum_o         (adder_sum)
  );

  vec_shifter u_shifter (
    .operator_i     (operator_i),
    .vector_mode_i  (vector_mode_i),
    .operand_a_i    (operand_a_i),
    .operand_b_i    (operand_b_i),
    .shift_result_o (shift_res)
  );

  vec_compare u_compare (
    .operator_i    (operator_i),
    .vector_mode_i (vector_mode_i),
    .operand_a_i   (operand_a_i),
    .operand_b_i   (operand_b_i),
    .cmp_lanes_o   (cmp_lanes),
    .minmax_o      (minmax_res)
  );

  // iterative unit, owns the ready handshake
  serial_div u_div (
    .clk          (clk),
    .reset_i      (reset_i),
    .enable_i     (enable_i),
    .operator_i   (operator_i),
    .operand_a_i  (operand_a_i),
    .operand_b_i  (operand_b_i),
    .ex_ready_i   (ex_ready_i),
    .div_result_o (div_res),
    .ready_o      (ready_o)
  );

  ////////////////////////////////////////////////////////////
  // result selection
  ////////////////////////////////////////////////////////////

  // top lane decides the scalar compare outcome
  assign comparison_result_o = cmp_lanes[alu_pkg::LANES_MAX-1];

  always_comb begin
    result_o = '0;
    case (operator_i)
      alu_pkg::ALU_ADD, alu_pkg::ALU_SUB: result_o = adder_sum;

      // plain logic ops need no unit of their own
      alu_pkg::ALU_AND: result_o = operand_a_i & operand_b_i;
      alu_pkg::ALU_OR:  result_o = operand_a_i | operand_b_i;
      alu_pkg::ALU_XOR: result_o = operand_a_i ^ operand_b_i;

      alu_pkg::ALU_SLL, alu_pkg::ALU_SRL,
      alu_pkg::ALU_SRA, alu_pkg::ALU_ROR: result_o = shift_res;

      // lane flags widen to a full byte each
      alu_pkg::ALU_EQ,  alu_pkg::ALU_NE,
      alu_pkg::ALU_GTS, alu_pkg::ALU_GES, alu_pkg::ALU_LTS, alu_pkg::ALU_LES,
      alu_pkg::ALU_GTU, alu_pkg::ALU_GEU, alu_pkg::ALU_LTU, alu_pkg::ALU_LEU: begin
        result_o = {{8{cmp_lanes[3]}}, {8{cmp_lanes[2]}},
                    {8{cmp_lanes[1]}}, {8{cmp_lanes[0]}}};
      end

      // set-less-than returns 0 or 1
      alu_pkg::ALU_SLTS, alu_pkg::ALU_SLTU: begin
        result_o = {{(alu_pkg::WORD_W-1){1'b0}}, comparison_result_o};
      end

      alu_pkg::ALU_MIN, alu_pkg::ALU_MINU,
      alu_pkg::ALU_MAX, alu_pkg::ALU_MAXU: result_o = minmax_res;

      alu_pkg::ALU_DIV, alu_pkg::ALU_DIVU,
      alu_pkg::ALU_REM, alu_pkg::ALU_REMU: result_o = div_res;

      default: result_o = '0;
    endcase
  end

endmodule

// ==== test/tb_alu_model.svh ====
// lane width in bits for a vector mode
function automatic int lane_width(alu_pkg::vec_mode_e mode);
  case (mode)
    alu_pkg::VEC_MODE16: return 16;
    alu_pkg::VEC_MODE8:  return 8;
    default:             return 32;
  endcase
endfunction

// lane i of v with zero or sign extension
function automatic longint lane_value(logic [31:0] v, int i, int w, bit sgn);
  longint u;
  u = longint'((v >> (i * w)) & ((64'd1 << w) - 1));
  if (sgn && u[w-1]) u = u - (longint'(1) << w);
  return u;
endfunction

// expected result of every single cycle opcode computed one lane at a time
function automatic logic [31:0] lane_expect(alu_pkg::alu_op_e op, alu_pkg::vec_mode_e mode,
                                            logic [31:0] a, logic [31:0] b);
  int          w;
  int          sh;
  bit          sgn;
  longint      x;
  longint      y;
  longint      r;
  logic [63:0] mask;
  logic [63:0] res;
  w    = lane_width(mode);
  mask = (64'd1 << w) - 1;
  res  = '0;
  sgn  = op inside {alu_pkg::ALU_GTS, alu_pkg::ALU_GES, alu_pkg::ALU_LTS, alu_pkg::ALU_LES,
                    alu_pkg::ALU_SLTS, alu_pkg::ALU_MIN, alu_pkg::ALU_MAX, alu_pkg::ALU_SRA};
  for (int i = 0; i < 32 / w; i++) begin
    x  = lane_value(a, i, w, sgn);
    y  = lane_value(b, i, w, sgn);
    // amount is the low bits of the lane of b
    sh = int'(lane_value(b, i, w, 1'b0)) & (w - 1);
    case (op)
      alu_pkg::ALU_ADD:  r = x + y;
      alu_pkg::ALU_SUB:  r = x - y;
      alu_pkg::ALU_AND:  r = x & y;
      alu_pkg::ALU_OR:   r = x | y;
      alu_pkg::ALU_XOR:  r = x ^ y;
      alu_pkg::ALU_SLL:  r = x << sh;
      alu_pkg::ALU_SRL, alu_pkg::ALU_SRA: r = x >>> sh;
      // bits leaving at the bottom come back in at the top of the lane
      alu_pkg::ALU_ROR:  r = (x >> sh) | (x << (w - sh));
      alu_pkg::ALU_EQ:   r = (x == y) ? -1 : 0;
      alu_pkg::ALU_NE:   r = (x != y) ? -1 : 0;
      alu_pkg::ALU_GTS, alu_pkg::ALU_GTU: r = (x > y) ? -1 : 0;
      alu_pkg::ALU_GES, alu_pkg::ALU_GEU: r = (x >= y) ? -1 : 0;
      alu_pkg::ALU_LTS, alu_pkg::ALU_LTU,
      alu_pkg::ALU_SLTS, alu_pkg::ALU_SLTU: r = (x < y) ? -1 : 0;
      alu_pkg::ALU_LES, alu_pkg::ALU_LEU: r = (x <= y) ? -1 : 0;
      alu_pkg::ALU_MIN, alu_pkg::ALU_MINU: r = (x < y) ? x : y;
      alu_pkg::ALU_MAX, alu_pkg::ALU_MAXU: r = (x > y) ? x : y;
      default: r = 0;
    endcase
    res = res | ((r & mask) << (i * w));
  end
  // set less than keeps only the top lane flag
  if (op inside {alu_pkg::ALU_SLTS, alu_pkg::ALU_SLTU}) res = {63'b0, res[31]};
  return res[31:0];
endfunction

// division rules with the two corner cases first
function automatic logic [31:0] div_expect(alu_pkg::alu_op_e op, logic [31:0] a,
                                           logic [31:0] b);
  bit          sgn;
  bit          want_rem;
  logic [31:0] q;
  logic [31:0] r;
  sgn      = (op == alu_pkg::ALU_DIV) || (op == alu_pkg::ALU_REM);
  want_rem = (op == alu_pkg::ALU_REM) || (op == alu_pkg::ALU_REMU);
  if (b == '0) begin
    q = '1;
    r = a;
  end else if (sgn && (a == 32'h8000_0000) && (b == '1)) begin
    q = a;
    r = '0;
  end else if (sgn) begin
    q = $signed(a) / $signed(b);
    r = $signed(a) % $signed(b);
  end else begin
    q = a / b;
    r = a % b;
  end
  return want_rem ? r : q;
endfunction

// ==== test/tb_alu.sv ====
`timescale 1ns/1ps

module tb_alu;

  localparam int VECS       = 12;
  localparam int DIV_RANDS  = 8;
  localparam int NUM_DIV    = 4 * (DIV_RANDS + 2) + 2;
  // per mode 5 arith and logic ops, 3 shifts, 12 compares, 4 min/max, plus ror
  localparam int COMB_VECS  = VECS * (3 * (5 + 3 + 12 + 4) + 1) + 2;
  // about 40 cycles a division, one a vector, longest stall, doubled
  localparam int MAX_CYCLES = 2 * (40 * NUM_DIV + COMB_VECS + 12 + 10);

  logic                clk;
  logic                reset_i;
  logic                enable_i;
  logic                ex_ready_i;
  alu_pkg::alu_op_e    operator_i;
  alu_pkg::vec_mode_e  vector_mode_i;
  alu_pkg::word_t      operand_a_i;
  alu_pkg::word_t      operand_b_i;
  alu_pkg::word_t      result_o;
  logic                comparison_result_o;
  logic                ready_o;
  logic                hold_chk;
  alu_pkg::vec_mode_e  modes [3] = '{alu_pkg::VEC_MODE32, alu_pkg::VEC_MODE16,
                                     alu_pkg::VEC_MODE8};
  int                  pass_cnt   = 0;
  int                  fail_cnt   = 0;
  int                  test_fails = 0;
  int                  cycle_cnt  = 0;
  string               cur_test   = "none";

  `include "tb_alu_model.svh"

  alu_top uut (
    .clk                 (clk),
    .reset_i             (reset_i),
    .enable_i            (enable_i),
    .operator_i          (operator_i),
    .vector_mode_i       (vector_mode_i),
    .operand_a_i         (operand_a_i),
    .operand_b_i         (operand_b_i),
    .ex_ready_i          (ex_ready_i),
    .result_o            (result_o),
    .comparison_result_o (comparison_result_o),
    .ready_o             (ready_o)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // stop a hung run
  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt > MAX_CYCLES) begin
      $display("run timed out after %0d cycles in test %s", cycle_cnt, cur_test);
      $display("sim failed");
      $finish;
    end
  end

  // while the consumer stalls, ready and the result hold
  hold_stable: assert property (@(posedge clk) disable iff (reset_i)
    hold_chk |=> ready_o && $stable(result_o))
    else begin
      $display("%s: result_o or ready_o changed while ex_ready_i was low", cur_test);
      fail_cnt++;
      test_fails++;
    end

  ////////////////////////////////////////////////////////////
  // checks and stimulus
  ////////////////////////////////////////////////////////////

  task automatic check_value(alu_pkg::word_t exp, alu_pkg::word_t act);
    assert (act === exp) pass_cnt++;
    else begin
      $display("mismatch %s %s expected %h actual %h", cur_test, operator_i.name(), exp, act);
      fail_cnt++;
      test_fails++;
    end
  endtask

  task automatic check_true(bit cond, string what);
    assert (cond) pass_cnt++;
    else begin
      $display("%s: %s", cur_test, what);
      fail_cnt++;
      test_fails++;
    end
  endtask

  task automatic start_test(string name);
    cur_test   = name;
    test_fails = 0;
  endtask

  task automatic finish_test();
    $display("test %-12s done, %0d errors", cur_test, test_fails);
  endtask

  // one single cycle op with outputs read at the falling edge
  task automatic check_comb(alu_pkg::alu_op_e op, alu_pkg::vec_mode_e mode,
                            alu_pkg::word_t a, alu_pkg::word_t b);
    alu_pkg::word_t exp;
    @(posedge clk);
    #1;
    enable_i      = 1'b1;
    operator_i    = op;
    vector_mode_i = mode;
    operand_a_i   = a;
    operand_b_i   = b;
    @(negedge clk);
    exp = lane_expect(op, mode, a, b);
    check_value(exp, result_o);
    // scalar flag mirrors the top lane
    if (op inside {[alu_pkg::ALU_EQ:alu_pkg::ALU_SLTU]}) begin
      check_value((op inside {alu_pkg::ALU_SLTS, alu_pkg::ALU_SLTU}) ? exp[0] : exp[31],
                  comparison_result_o);
    end
  endtask

  // random vectors over a range of opcodes in all modes
  task automatic sweep_ops(alu_pkg::alu_op_e first, alu_pkg::alu_op_e last);
    alu_pkg::word_t a;
    alu_pkg::word_t b;
    logic [3:0]     keep;
    for (int m = 0; m < 3; m++) begin
      for (int o = first; o <= last; o++) begin
        repeat (VECS) begin
          a    = $urandom;
          b    = $urandom;
          keep = $urandom_range(0, 15);
          // some equal bytes so ties get hit
          for (int k = 0; k < 4; k++) begin
            if (keep[k]) b[8*k +: 8] = a[8*k +: 8];
          end
          check_comb(alu_pkg::alu_op_e'(o), modes[m], a, b);
        end
      end
    end
  endtask

  // full division handshake where hold stalls the consumer after done
  task automatic run_div(alu_pkg::alu_op_e op, alu_pkg::word_t a, alu_pkg::word_t b, int hold);
    alu_pkg::word_t exp;
    exp = div_expect(op, a, b);
    @(posedge clk);
    #1;
    operator_i  = op;
    operand_a_i = a;
    operand_b_i = b;
    enable_i    = 1'b1;
    @(posedge clk);
    #1;
    check_true(ready_o === 1'b0, "ready_o stayed high after a division started");
    while (ready_o !== 1'b1) begin
      @(posedge clk);
      #1;
    end
    check_value(exp, result_o);
    if (hold > 0) begin
      hold_chk = 1'b1;
      repeat (hold) begin
        @(posedge clk);
        #1;
      end
      check_value(exp, result_o);
      hold_chk = 1'b0;
    end
    // take the result and drop the request together
    ex_ready_i = 1'b1;
    enable_i   = 1'b0;
    @(posedge clk);
    #1;
    ex_ready_i = 1'b0;
  endtask

  ////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(36106));
    reset_i       = 1'b1;
    enable_i      = 1'b0;
    ex_ready_i    = 1'b0;
    hold_chk      = 1'b0;
    operator_i    = alu_pkg::ALU_ADD;
    vector_mode_i = alu_pkg::VEC_MODE32;
    operand_a_i   = '0;
    operand_b_i   = '0;
    repeat (5) @(posedge clk);
    #1;
    reset_i = 1'b0;

    start_test("reset");
    check_true(ready_o === 1'b1, "ready_o was not high after reset");
    finish_test();

    start_test("arith_logic");
    // every byte wraps on its own with no carry into the next lane
    check_comb(alu_pkg::ALU_ADD, alu_pkg::VEC_MODE8, 32'hffff_ffff, 32'h0101_0101);
    check_comb(alu_pkg::ALU_SUB, alu_pkg::VEC_MODE16, 32'h0000_0000, 32'h0001_0001);
    sweep_ops(alu_pkg::ALU_ADD, alu_pkg::ALU_XOR);
    finish_test();

    start_test("shift");
    sweep_ops(alu_pkg::ALU_SLL, alu_pkg::ALU_SRA);
    repeat (VECS) check_comb(alu_pkg::ALU_ROR, alu_pkg::VEC_MODE32, $urandom, $urandom);
    finish_test();

    start_test("compare");
    sweep_ops(alu_pkg::ALU_EQ, alu_pkg::ALU_SLTU);
    finish_test();

    start_test("minmax");
    sweep_ops(alu_pkg::ALU_MIN, alu_pkg::ALU_MAXU);
    finish_test();

    start_test("divide");
    for (int o = alu_pkg::ALU_DIVU; o <= alu_pkg::ALU_REM; o++) begin
      // narrower divisors give larger quotients
      repeat (DIV_RANDS) begin
        run_div(alu_pkg::alu_op_e'(o), $urandom, $urandom >> $urandom_range(0, 24), 0);
      end
      run_div(alu_pkg::alu_op_e'(o), $urandom, 32'h0, 0);
      run_div(alu_pkg::alu_op_e'(o), 32'h8000_0000, 32'hffff_ffff, 0);
    end
    finish_test();

    start_test("backpressure");
    run_div(alu_pkg::ALU_DIVU, $urandom, $urandom >> 8, $urandom_range(1, 12));
    run_div(alu_pkg::ALU_REM, $urandom, $urandom >> 16, 0);
    finish_test();

    $display("checks passed %0d, failed %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// ==== verilog.f ====
+incdir+test
hdl/alu_pkg.sv
hdl/vec_adder.sv
hdl/vec_shifter.sv
hdl/vec_compare.sv
hdl/serial_div.sv
hdl/alu_top.sv
test/tb_alu.sv
